// ==== design/stereo_preview_pkg.sv ====
`default_nettype none

package stereo_preview_pkg;

    // ------------------------------------------------------------------
    //  Camera word format
    // ------------------------------------------------------------------

    localparam int LANES = 4;

    typedef logic [9:0]                         pix_t;
    // Lane 0 sits in the low bits
    typedef logic [LANES*$bits(pix_t)-1:0]      cam_word_t;
    typedef logic [1:0]                         lane_t;

    typedef logic [13:0]                        cam_h_t;
    typedef logic [12:0]                        cam_v_t;

    // ------------------------------------------------------------------
    //  Tile memory
    // ------------------------------------------------------------------

    localparam int TILE_SIZE    = 256;
    localparam int TILE_WORDS_X = TILE_SIZE / LANES;

    // Row above word column
    typedef logic [13:0]                        tile_addr_t;

    // ------------------------------------------------------------------
    //  Display geometry
    // ------------------------------------------------------------------

    localparam int DISP_WIDTH  = 640;
    localparam int DISP_HEIGHT = 480;

    typedef logic [12:0]                        disp_h_t;
    typedef logic [11:0]                        disp_v_t;

    // Each tile centred in its half of the screen
    localparam int WIN0_X = (DISP_WIDTH / 2 - TILE_SIZE) / 2;
    localparam int WIN1_X = WIN0_X + DISP_WIDTH / 2;
    localparam int WIN_Y  = (DISP_HEIGHT - TILE_SIZE) / 2;

    // Address stage plus memory output register
    localparam int READ_LATENCY = 2;

endpackage

`default_nettype wire

// ==== design/cam_word_if.sv ====
`default_nettype none

interface cam_word_if;

    import stereo_preview_pkg::*;

    logic       valid;
    logic       first;
    logic       last;
    cam_word_t  data;

    // Driven from the top-level ports
    modport source (
        output valid,
        output first,
        output last,
        output data
    );

    // No ready, every valid word is taken
    modport capture (
        input  valid,
        input  first,
        input  last,
        input  data
    );

endinterface

`default_nettype wire

// ==== design/cam_capture.sv ====
`default_nettype none

module cam_capture (
    input  var logic                            clk_i,
    input  var logic                            rst_i,
    cam_word_if.capture                         cam,
    output var logic                            wr_en_o,
    output var stereo_preview_pkg::tile_addr_t  wr_addr_o,
    output var stereo_preview_pkg::cam_word_t   wr_data_o
);

    import stereo_preview_pkg::*;

    logic       last_q;
    logic       valid_q;
    cam_h_t     x_q;
    cam_v_t     y_q;
    cam_word_t  data_q;

    // ------------------------------------------------------------------
    //  Stage 1: word coordinates
    // ------------------------------------------------------------------

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            last_q  <= 1'b0;
            valid_q <= 1'b0;
            x_q     <= '0;
            y_q     <= '0;
        end
        else begin
            valid_q <= cam.valid;
            if (cam.valid) begin
                last_q <= cam.last;
                if (cam.first) begin
                    x_q <= '0;
                    y_q <= '0;
                end
                else if (last_q) begin
                    // New line after a line end
                    x_q <= '0;
                    y_q <= y_q + 1'b1;
                end
                else begin
                    x_q <= x_q + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        data_q <= cam.data;
    end

    // ------------------------------------------------------------------
    //  Stage 2: clip to the tile and form the write port
    // ------------------------------------------------------------------

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            wr_en_o <= 1'b0;
        end
        else begin
            wr_en_o <= valid_q
                    && (x_q < cam_h_t'(TILE_WORDS_X))
                    && (y_q < cam_v_t'(TILE_SIZE));
        end
    end

    always_ff @(posedge clk_i) begin
        wr_addr_o <= {y_q[$clog2(TILE_SIZE)-1:0], x_q[$clog2(TILE_WORDS_X)-1:0]};
        wr_data_o <= data_q;
    end

    // Frame start and line end on one word would make the row ambiguous
    a_first_last_excl : assert property (
        @(posedge clk_i) disable iff (rst_i)
        cam.valid |-> !(cam.first && cam.last)
    );

endmodule

`default_nettype wire

// ==== design/tile_ram.sv ====
`default_nettype none

module tile_ram (
    input  var logic                            clk_i,
    input  var logic                            wr_en_i,
    input  var stereo_preview_pkg::tile_addr_t  wr_addr_i,
    input  var stereo_preview_pkg::cam_word_t   wr_data_i,
    input  var stereo_preview_pkg::tile_addr_t  rd_addr_i,
    output var stereo_preview_pkg::cam_word_t   rd_data_o
);

    import stereo_preview_pkg::*;

    // 256 rows of 64 words
    cam_word_t  mem [TILE_SIZE*TILE_WORDS_X];
    cam_word_t  rd_q;

    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // Array read then output register
    always_ff @(posedge clk_i) begin
        rd_q      <= mem[rd_addr_i];
        rd_data_o <= rd_q;
    end

    // Capture path must hand over a resolved address with its enable
    a_wr_addr_known : assert property (
        @(posedge clk_i)
        wr_en_i |-> !$isunknown(wr_addr_i)
    );

endmodule

`default_nettype wire

// ==== design/raster_scan.sv ====
`default_nettype none

module raster_scan (
    input  var logic                            clk_i,
    input  var logic                            rst_i,
    input  var logic                            enable_i,
    output var logic                            valid_o,
    output var stereo_preview_pkg::disp_h_t     x_o,
    output var stereo_preview_pkg::disp_v_t     y_o,
    output var logic                            first_o,
    output var logic                            last_o
);

    import stereo_preview_pkg::*;

    disp_h_t    x_q;
    disp_v_t    y_q;
    logic       x_end;
    logic       y_end;

    assign x_end = (x_q == disp_h_t'(DISP_WIDTH - 1));
    assign y_end = (y_q == disp_v_t'(DISP_HEIGHT - 1));

    // ------------------------------------------------------------------
    //  Position counters
    // ------------------------------------------------------------------

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            x_q <= '0;
            y_q <= '0;
        end
        else if (enable_i) begin
            if (x_end) begin
                x_q <= '0;
                if (y_end) begin
                    y_q <= '0;
                end
                else begin
                    y_q <= y_q + 1'b1;
                end
            end
            else begin
                x_q <= x_q + 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------
    //  Outputs for the current position
    // ------------------------------------------------------------------

    assign valid_o = enable_i;
    assign x_o     = x_q;
    assign y_o     = y_q;

    // markers only on positions actually scanned
    assign first_o = enable_i && (x_q == '0) && (y_q == '0);
    assign last_o  = enable_i && x_end;

    a_x_in_range : assert property (
        @(posedge clk_i) disable iff (rst_i)
        x_o < disp_h_t'(DISP_WIDTH)
    );

endmodule

`default_nettype wire

// ==== design/window_mux.sv ====
`default_nettype none

module window_mux (
    input  var logic                            clk_i,
    input  var logic                            rst_i,
    input  var logic                            scan_valid_i,
    input  var logic                            scan_first_i,
    input  var logic                            scan_last_i,
    input  var stereo_preview_pkg::disp_h_t     scan_x_i,
    input  var stereo_preview_pkg::disp_v_t     scan_y_i,
    output var stereo_preview_pkg::tile_addr_t  rd_addr0_o,
    output var stereo_preview_pkg::tile_addr_t  rd_addr1_o,
    input  var stereo_preview_pkg::cam_word_t   rd_data0_i,
    input  var stereo_preview_pkg::cam_word_t   rd_data1_i,
    output var logic                            pix_valid_o,
    output var logic                            pix_first_o,
    output var logic                            pix_last_o,
    output var stereo_preview_pkg::pix_t        pix_data_o
);

    import stereo_preview_pkg::*;

    disp_h_t    off0_x;
    disp_h_t    off1_x;
    disp_v_t    off_y;
    logic       hit0;
    logic       hit1;
    logic       hit0_q1;
    logic       hit1_q1;
    logic       hit0_q2;
    logic       hit1_q2;
    lane_t      lane0_q1;
    lane_t      lane1_q1;
    lane_t      lane0_q2;
    lane_t      lane1_q2;
    logic       valid_q1;
    logic       first_q1;
    logic       last_q1;

    // ------------------------------------------------------------------
    //  Window offsets and read addresses
    // ------------------------------------------------------------------

    // Left of or above a window wraps to a large value and misses
    assign off0_x = scan_x_i - disp_h_t'(WIN0_X);
    assign off1_x = scan_x_i - disp_h_t'(WIN1_X);
    assign off_y  = scan_y_i - disp_v_t'(WIN_Y);

    assign hit0 = (off0_x < disp_h_t'(TILE_SIZE)) && (off_y < disp_v_t'(TILE_SIZE));
    assign hit1 = (off1_x < disp_h_t'(TILE_SIZE)) && (off_y < disp_v_t'(TILE_SIZE));

    assign rd_addr0_o = {off_y[7:0], off0_x[7:2]};
    assign rd_addr1_o = {off_y[7:0], off1_x[7:2]};

    // ------------------------------------------------------------------
    //  Select pipeline, matched to the memory latency
    // ------------------------------------------------------------------

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            {valid_q1, first_q1, last_q1}          <= '0;
            {pix_valid_o, pix_first_o, pix_last_o} <= '0;
            {hit0_q1, hit1_q1, hit0_q2, hit1_q2}   <= '0;
            {lane0_q1, lane1_q1, lane0_q2, lane1_q2} <= '0;
        end
        else begin
            valid_q1    <= scan_valid_i;
            first_q1    <= scan_first_i;
            last_q1     <= scan_last_i;
            hit0_q1     <= hit0;
            hit1_q1     <= hit1;
            lane0_q1    <= off0_x[1:0];
            lane1_q1    <= off1_x[1:0];
            pix_valid_o <= valid_q1;
            pix_first_o <= first_q1;
            pix_last_o  <= last_q1;
            hit0_q2     <= hit0_q1;
            hit1_q2     <= hit1_q1;
            lane0_q2    <= lane0_q1;
            lane1_q2    <= lane1_q1;
        end
    end

    always_comb begin
        if (hit0_q2) begin
            pix_data_o = rd_data0_i[lane0_q2*$bits(pix_t) +: $bits(pix_t)];
        end
        else if (hit1_q2) begin
            pix_data_o = rd_data1_i[lane1_q2*$bits(pix_t) +: $bits(pix_t)];
        end
        else begin
            pix_data_o = '0;
        end
    end

    // Windows must not overlap for the priority above to be meaningless
    a_hits_exclusive : assert property (
        @(posedge clk_i) disable iff (rst_i)
        scan_valid_i |-> !(hit0 && hit1)
    );

endmodule

`default_nettype wire

// ==== design/stereo_preview_top.sv ====
`default_nettype none

module stereo_preview_top (
    input  var logic                            axi4s_cam0_rx,
    input  var logic                            sys_reset,
    input  var logic                            cam0_valid_i,
    input  var logic                            cam0_first_i,
    input  var logic                            cam0_last_i,
    input  var stereo_preview_pkg::cam_word_t   cam0_data_i,
    input  var logic                            cam1_valid_i,
    input  var logic                            cam1_first_i,
    input  var logic                            cam1_last_i,
    input  var stereo_preview_pkg::cam_word_t   cam1_data_i,
    input  var logic                            scan_enable_i,
    output var logic                            pix_valid_o,
    output var logic                            pix_first_o,
    output var logic                            pix_last_o,
    output var stereo_preview_pkg::pix_t        pix_data_o
);

    import stereo_preview_pkg::*;

    logic       wr_en0;
    logic       wr_en1;
    tile_addr_t wr_addr0;
    tile_addr_t wr_addr1;
    cam_word_t  wr_data0;
    cam_word_t  wr_data1;
    tile_addr_t rd_addr0;
    tile_addr_t rd_addr1;
    cam_word_t  rd_data0;
    cam_word_t  rd_data1;
    logic       scan_valid;
    logic       scan_first;
    logic       scan_last;
    disp_h_t    scan_x;
    disp_v_t    scan_y;

    // ------------------------------------------------------------------
    //  Capture paths
    // ------------------------------------------------------------------

    cam_word_if cam0_if ();
    cam_word_if cam1_if ();

    assign cam0_if.valid = cam0_valid_i;
    assign cam0_if.first = cam0_first_i;
    assign cam0_if.last  = cam0_last_i;
    assign cam0_if.data  = cam0_data_i;
    assign cam1_if.valid = cam1_valid_i;
    assign cam1_if.first = cam1_first_i;
    assign cam1_if.last  = cam1_last_i;
    assign cam1_if.data  = cam1_data_i;

    cam_capture u_capture0 (
        .clk_i      (axi4s_cam0_rx),
        .rst_i      (sys_reset),
        .cam        (cam0_if.capture),
        .wr_en_o    (wr_en0),
        .wr_addr_o  (wr_addr0),
        .wr_data_o  (wr_data0)
    );

    cam_capture u_capture1 (
        .clk_i      (axi4s_cam0_rx),
        .rst_i      (sys_reset),
        .cam        (cam1_if.capture),
        .wr_en_o    (wr_en1),
        .wr_addr_o  (wr_addr1),
        .wr_data_o  (wr_data1)
    );

    tile_ram u_tile0 (
        .clk_i      (axi4s_cam0_rx),
        .wr_en_i    (wr_en0),
        .wr_addr_i  (wr_addr0),
        .wr_data_i  (wr_data0),
        .rd_addr_i  (rd_addr0),
        .rd_data_o  (rd_data0)
    );

    tile_ram u_tile1 (
        .clk_i      (axi4s_cam0_rx),
        .wr_en_i    (wr_en1),
        .wr_addr_i  (wr_addr1),
        .wr_data_i  (wr_data1),
        .rd_addr_i  (rd_addr1),
        .rd_data_o  (rd_data1)
    );

    // ------------------------------------------------------------------
    //  Display read path
    // ------------------------------------------------------------------

    raster_scan u_scan (
        .clk_i      (axi4s_cam0_rx),
        .rst_i      (sys_reset),
        .enable_i   (scan_enable_i),
        .valid_o    (scan_valid),
        .x_o        (scan_x),
        .y_o        (scan_y),
        .first_o    (scan_first),
        .last_o     (scan_last)
    );

    window_mux u_mux (
        .clk_i          (axi4s_cam0_rx),
        .rst_i          (sys_reset),
        .scan_valid_i   (scan_valid),
        .scan_first_i   (scan_first),
        .scan_last_i    (scan_last),
        .scan_x_i       (scan_x),
        .scan_y_i       (scan_y),
        .rd_addr0_o     (rd_addr0),
        .rd_addr1_o     (rd_addr1),
        .rd_data0_i     (rd_data0),
        .rd_data1_i     (rd_data1),
        .pix_valid_o    (pix_valid_o),
        .pix_first_o    (pix_first_o),
        .pix_last_o     (pix_last_o),
        .pix_data_o     (pix_data_o)
    );

endmodule

`default_nettype wire

// ==== dv/stereo_preview_tb.sv ====
`default_nettype none

module stereo_preview_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import stereo_preview_pkg::*;

    localparam int CLK_HALF       = 2;
    localparam int DRIVE_DELAY    = 1;
    localparam int RESET_CYCLES   = 8;
    localparam int FRAME_POS      = DISP_WIDTH * DISP_HEIGHT;
    localparam int LINE_WORDS     = 80;
    localparam int LINES_FULL     = 270;
    localparam int LINES_SHORT    = 100;
    // Valid gaps at most double a capture
    localparam int CAPTURE_LEN    = 2 * LINE_WORDS * (LINES_FULL + LINES_SHORT);
    localparam int TIMEOUT_CYCLES = 2 * (CAPTURE_LEN + 3 * FRAME_POS);

    logic       axi4s_cam0_rx = 1'b0;
    logic       sys_reset;
    logic       cam0_valid_i;
    logic       cam0_first_i;
    logic       cam0_last_i;
    cam_word_t  cam0_data_i;
    logic       cam1_valid_i;
    logic       cam1_first_i;
    logic       cam1_last_i;
    cam_word_t  cam1_data_i;
    logic       scan_enable_i;
    logic       pix_valid_o;
    logic       pix_first_o;
    logic       pix_last_o;
    pix_t       pix_data_o;

    // Shadow copies of both tiles
    cam_word_t  shadow [2][TILE_SIZE*TILE_WORDS_X];

    // Expected outputs per scan cycle, index 0 is the newest
    logic       pipe_en    [READ_LATENCY+1];
    logic       pipe_first [READ_LATENCY+1];
    logic       pipe_last  [READ_LATENCY+1];
    pix_t       pipe_pix   [READ_LATENCY+1];

    int         scan_x;
    int         scan_y;
    int         cycle_count = 0;
    int         pixel_count = 0;
    int         error_count = 0;
    string      current_test = "reset_state";

    always #CLK_HALF axi4s_cam0_rx = ~axi4s_cam0_rx;

    stereo_preview_top stereo_preview_top_inst (
        .axi4s_cam0_rx  (axi4s_cam0_rx),
        .sys_reset      (sys_reset),
        .cam0_valid_i   (cam0_valid_i),
        .cam0_first_i   (cam0_first_i),
        .cam0_last_i    (cam0_last_i),
        .cam0_data_i    (cam0_data_i),
        .cam1_valid_i   (cam1_valid_i),
        .cam1_first_i   (cam1_first_i),
        .cam1_last_i    (cam1_last_i),
        .cam1_data_i    (cam1_data_i),
        .scan_enable_i  (scan_enable_i),
        .pix_valid_o    (pix_valid_o),
        .pix_first_o    (pix_first_o),
        .pix_last_o     (pix_last_o),
        .pix_data_o     (pix_data_o)
    );

    // ------------------------------------------------------------------
    //  Reference model and compare
    // ------------------------------------------------------------------

    function automatic pix_t expected_pixel(input int x, input int y);
        int         tile;
        int         ox;
        int         oy;
        cam_word_t  word;
        tile = -1;
        ox   = 0;
        oy   = y - WIN_Y;
        if (oy >= 0 && oy < TILE_SIZE) begin
            if (x >= WIN0_X && x < WIN0_X + TILE_SIZE) begin
                tile = 0;
                ox   = x - WIN0_X;
            end
            else if (x >= WIN1_X && x < WIN1_X + TILE_SIZE) begin
                tile = 1;
                ox   = x - WIN1_X;
            end
        end
        if (tile < 0) begin
            return '0;
        end
        word = shadow[tile][oy * TILE_WORDS_X + ox / LANES];
        return word[(ox % LANES) * $bits(pix_t) +: $bits(pix_t)];
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            error_count++;
            $display("error %s %s: expected %0d, actual %0d",
                     current_test, what, expected, actual);
            $display("Testbench failed");
            $fatal(1, "output mismatch");
        end
    endtask

    // Outputs are sampled mid-cycle, well away from the clock edge
    always @(negedge axi4s_cam0_rx) begin
        for (int i = READ_LATENCY; i > 0; i--) begin
            pipe_en[i]    = pipe_en[i-1];
            pipe_first[i] = pipe_first[i-1];
            pipe_last[i]  = pipe_last[i-1];
            pipe_pix[i]   = pipe_pix[i-1];
        end
        pipe_en[0]    = scan_enable_i;
        pipe_first[0] = scan_enable_i && scan_x == 0 && scan_y == 0;
        pipe_last[0]  = scan_enable_i && scan_x == DISP_WIDTH - 1;
        pipe_pix[0]   = expected_pixel(scan_x, scan_y);

        if (sys_reset) begin
            scan_x = 0;
            scan_y = 0;
        end
        else if (scan_enable_i) begin
            if (scan_x == DISP_WIDTH - 1) begin
                scan_x = 0;
                scan_y = (scan_y == DISP_HEIGHT - 1) ? 0 : scan_y + 1;
            end
            else begin
                scan_x++;
            end
        end

        if (cycle_count > 0) begin
            check_value("pix_valid", pipe_en[READ_LATENCY], pix_valid_o);
            check_value("pix_first", pipe_first[READ_LATENCY], pix_first_o);
            check_value("pix_last", pipe_last[READ_LATENCY], pix_last_o);
            if (pipe_en[READ_LATENCY]) begin
                check_value("pix_data", pipe_pix[READ_LATENCY], pix_data_o);
                pixel_count++;
            end
        end
    end

    always @(posedge axi4s_cam0_rx) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, stimulus did not complete", cycle_count);
            $display("Testbench failed");
            $fatal(1, "timeout");
        end
    end

    // ------------------------------------------------------------------
    //  Stimulus
    // ------------------------------------------------------------------

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge axi4s_cam0_rx);
    endtask

    function automatic cam_word_t random_word();
        logic [63:0] r;
        r = {$urandom(), $urandom()};
        return r[$bits(cam_word_t)-1:0];
    endfunction

    task automatic drive_cam(input int cam, input logic valid, input logic first,
                             input logic last, input cam_word_t data);
        if (cam == 0) begin
            cam0_valid_i = valid;
            cam0_first_i = first;
            cam0_last_i  = last;
            cam0_data_i  = data;
        end
        else begin
            cam1_valid_i = valid;
            cam1_first_i = first;
            cam1_last_i  = last;
            cam1_data_i  = data;
        end
    endtask

    // One frame of random words, valid low about a quarter of the time
    task automatic send_frame(input int cam, input int lines, input int words);
        int         l;
        int         w;
        logic       v;
        cam_word_t  data;
        l = 0;
        w = 0;
        while (l < lines) begin
            @(posedge axi4s_cam0_rx);
            #DRIVE_DELAY;
            v    = ($urandom_range(3) != 0);
            data = random_word();
            if (v) begin
                drive_cam(cam, 1'b1, l == 0 && w == 0, w == words - 1, data);
                if (w < TILE_WORDS_X && l < TILE_SIZE) begin
                    shadow[cam][l * TILE_WORDS_X + w] = data;
                end
                if (w == words - 1) begin
                    w = 0;
                    l++;
                end
                else begin
                    w++;
                end
            end
            else begin
                // Idle data is junk and must be ignored
                drive_cam(cam, 1'b0, 1'b0, 1'b0, data);
            end
        end
        @(posedge axi4s_cam0_rx);
        #DRIVE_DELAY;
        drive_cam(cam, 1'b0, 1'b0, 1'b0, '0);
    endtask

    task automatic scan_frame(input logic pauses);
        int     n;
        logic   en;
        n = 0;
        while (n < FRAME_POS) begin
            @(posedge axi4s_cam0_rx);
            #DRIVE_DELAY;
            en = pauses ? ($urandom_range(7) != 0) : 1'b1;
            scan_enable_i = en;
            if (en) begin
                n++;
            end
        end
        @(posedge axi4s_cam0_rx);
        #DRIVE_DELAY;
        scan_enable_i = 1'b0;
    endtask

    initial begin
        void'($urandom(32'h4ef2_2316));
        sys_reset     = 1'b1;
        scan_enable_i = 1'b0;
        drive_cam(0, 1'b0, 1'b0, 1'b0, '0);
        drive_cam(1, 1'b0, 1'b0, 1'b0, '0);
        for (int a = 0; a < TILE_SIZE * TILE_WORDS_X; a++) begin
            shadow[0][a] = '0;
            shadow[1][a] = '0;
        end
        for (int i = 0; i <= READ_LATENCY; i++) begin
            pipe_en[i]    = 1'b0;
            pipe_first[i] = 1'b0;
            pipe_last[i]  = 1'b0;
            pipe_pix[i]   = '0;
        end

        repeat (RESET_CYCLES) @(posedge axi4s_cam0_rx);
        #DRIVE_DELAY;
        sys_reset = 1'b0;
        wait_cycles(16);

        current_test = "random_frames";
        fork
            send_frame(0, LINES_FULL, LINE_WORDS);
            send_frame(1, LINES_FULL, LINE_WORDS);
        join
        wait_cycles(8);
        scan_frame(1'b0);
        wait_cycles(8);

        // Rows past the short frame keep the first frame
        current_test = "frame_restart";
        fork
            send_frame(0, LINES_SHORT, LINE_WORDS);
            send_frame(1, LINES_SHORT, LINE_WORDS);
        join
        wait_cycles(8);
        scan_frame(1'b0);
        wait_cycles(8);

        current_test = "scan_pauses";
        scan_frame(1'b1);
        wait_cycles(8);

        check_value("pixel_count", 3 * FRAME_POS, pixel_count);
        if (error_count == 0) begin
            $display("Testbench passed");
            $finish;
        end
        else begin
            $display("Testbench failed");
            $fatal(1, "checks failed");
        end
    end

endmodule

`default_nettype wire

// ==== build.f ====
design/stereo_preview_pkg.sv
design/cam_word_if.sv
design/cam_capture.sv
design/tile_ram.sv
design/raster_scan.sv
design/window_mux.sv
design/stereo_preview_top.sv
dv/stereo_preview_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the stereo preview testbench with Verilator

rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f build.f \
    --top-module stereo_preview_tb -o sim_tb \
    && ./obj_dir/sim_tb > sim.log 2>&1
cat sim.log
grep -q "^Testbench passed$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
